/* design/rocache_beat_counter.sv */
// Wraps to zero after the last count; mode_i low counts line words, high counts lines
`timescale 1ns/1ps

module rocache_beat_counter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                step_i,
  input  logic                mode_i,
  output rocache_pkg::index_t count_o,
  output logic                last_o
);

  rocache_pkg::index_t count_q;
  rocache_pkg::index_t final_count;

  // Refill walks the words of one line, flush walks every line
  assign final_count = mode_i ? rocache_pkg::index_t'(rocache_pkg::LINE_COUNT - 1)
                              : rocache_pkg::index_t'(rocache_pkg::WORDS_PER_LINE - 1);

  assign last_o  = (count_q == final_count);
  assign count_o = count_q;

  // ----------------------------------------------------------------------
  // Count register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (step_i) begin
      if (last_o) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + rocache_pkg::index_t'(1);
      end
    end
  end

endmodule

/* design/rocache_ctrl.sv */
// One request at a time; slave inputs must stay stable until ack_o or err_o is seen
`timescale 1ns/1ps

module rocache_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Slave port
  input  logic                    cyc_i,
  input  logic                    stb_i,
  input  logic                    we_i,
  input  wb_pkg::addr_t           adr_i,
  input  wb_pkg::data_t           dat_i,
  input  wb_pkg::sel_t            sel_i,
  output wb_pkg::data_t           dat_o,
  output logic                    ack_o,
  output logic                    err_o,
  input  logic                    cacheable_i,
  input  logic                    flush_valid_i,
  output logic                    flush_ready_o,
  // Master port
  output logic                    m_cyc_o,
  output logic                    m_stb_o,
  output logic                    m_we_o,
  output wb_pkg::addr_t           m_adr_o,
  output wb_pkg::data_t           m_dat_o,
  output wb_pkg::sel_t            m_sel_o,
  input  wb_pkg::data_t           m_dat_i,
  input  logic                    m_ack_i,
  input  logic                    m_err_i,
  // Counter
  output logic                    cnt_clear_o,
  output logic                    cnt_step_o,
  output logic                    cnt_mode_o,
  input  rocache_pkg::index_t     count_i,
  input  logic                    last_i,
  // Tag and data stores
  output rocache_pkg::index_t     rd_index_o,
  output logic                    wr_en_o,
  output rocache_pkg::index_t     wr_index_o,
  output rocache_pkg::tag_entry_t tag_wr_o,
  output rocache_pkg::line_t      line_wr_o,
  input  rocache_pkg::tag_entry_t tag_rd_i,
  input  rocache_pkg::line_t      line_rd_i
);

  typedef enum logic [2:0] {
    ST_FLUSH,
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_FILL_WRITE,
    ST_BYPASS,
    ST_RESPOND
  } state_e;

  state_e                                  state_q;
  state_e                                  state_d;
  logic                                    gap_q;
  logic                                    err_q;
  logic                                    init_done_q;
  logic                                    flush_ready_q;
  rocache_pkg::line_t                      line_q;
  wb_pkg::data_t                           data_q;
  logic [rocache_pkg::WORD_OFF_W-1:0]      req_off;
  rocache_pkg::index_t                     req_index;
  logic [rocache_pkg::TAG_W-1:0]           req_tag;
  logic                                    hit;
  logic                                    beat_done;

  // ----------------------------------------------------------------------
  // Request address split
  // ----------------------------------------------------------------------
  assign req_off   = adr_i[rocache_pkg::BYTE_OFF_W +: rocache_pkg::WORD_OFF_W];
  assign req_index = adr_i[rocache_pkg::BYTE_OFF_W + rocache_pkg::WORD_OFF_W +:
                           rocache_pkg::INDEX_W];
  assign req_tag   = adr_i[wb_pkg::ADDR_W-1 -: rocache_pkg::TAG_W];

  // Stores are read with the held request address, valid one cycle later in lookup
  assign rd_index_o = req_index;
  assign hit        = tag_rd_i.valid && (tag_rd_i.tag == req_tag);

  // A master cycle ends on either ack or err
  assign beat_done = m_cyc_o && (m_ack_i || m_err_i);

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_FLUSH: begin
        if (last_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_IDLE: begin
        // The cycle with flush_ready_o high closes the handshake, so no restart then
        if (flush_valid_i && !flush_ready_q) begin
          state_d = ST_FLUSH;
        end else if (cyc_i && stb_i) begin
          state_d = cacheable_i ? ST_LOOKUP : ST_BYPASS;
        end
      end
      ST_LOOKUP: begin
        state_d = hit ? ST_RESPOND : ST_REFILL;
      end
      ST_REFILL: begin
        if (beat_done && last_i) begin
          state_d = ST_FILL_WRITE;
        end
      end
      ST_FILL_WRITE: begin
        state_d = ST_RESPOND;
      end
      ST_BYPASS: begin
        if (beat_done) begin
          state_d = ST_RESPOND;
        end
      end
      ST_RESPOND: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_FLUSH;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // Master port, counter and store controls
  // ----------------------------------------------------------------------
  always_comb begin
    m_cyc_o        = 1'b0;
    m_stb_o        = 1'b0;
    m_we_o         = 1'b0;
    m_adr_o        = adr_i;
    m_dat_o        = dat_i;
    m_sel_o        = sel_i;
    cnt_clear_o    = 1'b0;
    cnt_step_o     = 1'b0;
    cnt_mode_o     = 1'b0;
    wr_en_o        = 1'b0;
    wr_index_o     = req_index;
    tag_wr_o.valid = !err_q;
    tag_wr_o.tag   = req_tag;
    unique case (state_q)
      ST_FLUSH: begin
        // One invalid entry per cycle, walking all lines
        cnt_mode_o     = 1'b1;
        cnt_step_o     = 1'b1;
        wr_en_o        = 1'b1;
        wr_index_o     = count_i;
        tag_wr_o.valid = 1'b0;
      end
      ST_IDLE, ST_LOOKUP: begin
        cnt_clear_o = 1'b1;
      end
      ST_REFILL: begin
        // Single-beat reads with one idle cycle between them
        m_cyc_o    = !gap_q;
        m_stb_o    = !gap_q;
        m_adr_o    = {adr_i[wb_pkg::ADDR_W-1:rocache_pkg::BYTE_OFF_W + rocache_pkg::WORD_OFF_W],
                      count_i[rocache_pkg::WORD_OFF_W-1:0],
                      {rocache_pkg::BYTE_OFF_W{1'b0}}};
        m_sel_o    = '1;
        cnt_step_o = beat_done;
      end
      ST_FILL_WRITE: begin
        // Entry stays invalid if any refill beat failed
        wr_en_o = 1'b1;
      end
      ST_BYPASS: begin
        m_cyc_o = 1'b1;
        m_stb_o = 1'b1;
        m_we_o  = we_i;
      end
      default: begin
      end
    endcase
  end

  assign line_wr_o     = line_q;
  assign dat_o         = data_q;
  assign ack_o         = (state_q == ST_RESPOND) && !err_q;
  assign err_o         = (state_q == ST_RESPOND) && err_q;
  assign flush_ready_o = flush_ready_q;

  // ----------------------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ST_FLUSH;
      gap_q         <= 1'b0;
      err_q         <= 1'b0;
      init_done_q   <= 1'b0;
      flush_ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      gap_q   <= (state_q == ST_REFILL) && beat_done && !last_i;
      // The flush after reset has no requester, so it gives no ready pulse
      flush_ready_q <= (state_q == ST_FLUSH) && last_i && init_done_q;
      if (state_q == ST_IDLE) begin
        init_done_q <= 1'b1;
        err_q       <= 1'b0;
      end else if (beat_done && m_err_i) begin
        err_q <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Line assembly and response data
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_REFILL) && beat_done) begin
      line_q[count_i[rocache_pkg::WORD_OFF_W-1:0]] <= m_dat_i;
    end
    if (state_q == ST_LOOKUP) begin
      data_q <= line_rd_i[req_off];
    end else if (state_q == ST_FILL_WRITE) begin
      data_q <= line_q[req_off];
    end else if ((state_q == ST_BYPASS) && beat_done) begin
      data_q <= m_dat_i;
    end
  end

endmodule

/* design/rocache_line_store.sv */
// Read data appears one cycle after the index; a same-cycle write to that index reads old data
`timescale 1ns/1ps

module rocache_line_store #(
  parameter type payload_t = rocache_pkg::line_t
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  rocache_pkg::index_t rd_index_i,
  input  logic                wr_en_i,
  input  rocache_pkg::index_t wr_index_i,
  input  payload_t            wr_data_i,
  output payload_t            rd_data_o
);

  payload_t mem_q [rocache_pkg::LINE_COUNT];

  // ----------------------------------------------------------------------
  // Write port
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_index_i] <= wr_data_i;
    end
  end

  // ----------------------------------------------------------------------
  // Registered read port
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_o <= '0;
    end else begin
      rd_data_o <= mem_q[rd_index_i];
    end
  end

endmodule

/* design/rocache_pkg.sv */
// Geometry of a direct-mapped cache with 16 lines of 4 words; widths follow wb_pkg
package rocache_pkg;

  // ----------------------------------------------------------------------
  // Geometry
  // ----------------------------------------------------------------------
  localparam int unsigned WORDS_PER_LINE = 4;
  localparam int unsigned LINE_COUNT     = 16;
  localparam int unsigned NR_WINDOWS     = 2;

  // Address split, from the lsb upwards: byte, word offset, index, tag
  localparam int unsigned BYTE_OFF_W = 2;
  localparam int unsigned WORD_OFF_W = 2;
  localparam int unsigned INDEX_W    = 4;
  localparam int unsigned TAG_W      = wb_pkg::ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

  // ----------------------------------------------------------------------
  // Storage types
  // ----------------------------------------------------------------------
  // Word 0 sits in the low bits of the line
  typedef logic [WORDS_PER_LINE-1:0][wb_pkg::DATA_W-1:0] line_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  typedef logic [INDEX_W-1:0] index_t;

endpackage

/* design/rocache_region_decode.sv */
// Windows are half-open [start, end); end must be above start, writes never cacheable
`timescale 1ns/1ps

module rocache_region_decode (
  input  logic          enable_i,
  input  wb_pkg::addr_t adr_i,
  input  logic          we_i,
  input  wb_pkg::addr_t start_addr_i [rocache_pkg::NR_WINDOWS],
  input  wb_pkg::addr_t end_addr_i   [rocache_pkg::NR_WINDOWS],
  output logic          cacheable_o
);

  logic [rocache_pkg::NR_WINDOWS-1:0] win_hit;
  logic                               in_window;

  // ----------------------------------------------------------------------
  // Per-window range compare
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < rocache_pkg::NR_WINDOWS; i++) begin : gen_window
    assign win_hit[i] = (adr_i >= start_addr_i[i]) && (adr_i < end_addr_i[i]);
  end

  // Overlapping windows are harmless, any match counts
  assign in_window = |win_hit;

  // Only reads are served from the line store
  assign cacheable_o = enable_i && !we_i && in_window;

endmodule

/* design/rocache_top.sv */
// Read-only cache between a Wishbone classic slave and master; writes always bypass
`timescale 1ns/1ps

module rocache_top (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          enable_i,
  input  wb_pkg::addr_t start_addr_i [rocache_pkg::NR_WINDOWS],
  input  wb_pkg::addr_t end_addr_i   [rocache_pkg::NR_WINDOWS],
  input  logic          flush_valid_i,
  output logic          flush_ready_o,
  // Slave port
  input  logic          cyc_i,
  input  logic          stb_i,
  input  logic          we_i,
  input  wb_pkg::addr_t adr_i,
  input  wb_pkg::data_t dat_i,
  input  wb_pkg::sel_t  sel_i,
  output wb_pkg::data_t dat_o,
  output logic          ack_o,
  output logic          err_o,
  // Master port
  output logic          m_cyc_o,
  output logic          m_stb_o,
  output logic          m_we_o,
  output wb_pkg::addr_t m_adr_o,
  output wb_pkg::data_t m_dat_o,
  output wb_pkg::sel_t  m_sel_o,
  input  wb_pkg::data_t m_dat_i,
  input  logic          m_ack_i,
  input  logic          m_err_i
);

  logic                    cacheable;
  logic                    cnt_clear;
  logic                    cnt_step;
  logic                    cnt_mode;
  rocache_pkg::index_t     count;
  logic                    cnt_last;
  rocache_pkg::index_t     rd_index;
  logic                    wr_en;
  rocache_pkg::index_t     wr_index;
  rocache_pkg::tag_entry_t tag_wr;
  rocache_pkg::tag_entry_t tag_rd;
  rocache_pkg::line_t      line_wr;
  rocache_pkg::line_t      line_rd;

  rocache_region_decode u_region_decode (
    .enable_i     (enable_i),
    .adr_i        (adr_i),
    .we_i         (we_i),
    .start_addr_i (start_addr_i),
    .end_addr_i   (end_addr_i),
    .cacheable_o  (cacheable)
  );

  rocache_beat_counter u_beat_counter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (cnt_clear),
    .step_i  (cnt_step),
    .mode_i  (cnt_mode),
    .count_o (count),
    .last_o  (cnt_last)
  );

  // Tags and lines share the index and write strobe
  rocache_line_store #(
    .payload_t (rocache_pkg::tag_entry_t)
  ) u_tag_store (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_index_i (rd_index),
    .wr_en_i    (wr_en),
    .wr_index_i (wr_index),
    .wr_data_i  (tag_wr),
    .rd_data_o  (tag_rd)
  );

  rocache_line_store #(
    .payload_t (rocache_pkg::line_t)
  ) u_data_store (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_index_i (rd_index),
    .wr_en_i    (wr_en),
    .wr_index_i (wr_index),
    .wr_data_i  (line_wr),
    .rd_data_o  (line_rd)
  );

  rocache_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cyc_i         (cyc_i),
    .stb_i         (stb_i),
    .we_i          (we_i),
    .adr_i         (adr_i),
    .dat_i         (dat_i),
    .sel_i         (sel_i),
    .dat_o         (dat_o),
    .ack_o         (ack_o),
    .err_o         (err_o),
    .cacheable_i   (cacheable),
    .flush_valid_i (flush_valid_i),
    .flush_ready_o (flush_ready_o),
    .m_cyc_o       (m_cyc_o),
    .m_stb_o       (m_stb_o),
    .m_we_o        (m_we_o),
    .m_adr_o       (m_adr_o),
    .m_dat_o       (m_dat_o),
    .m_sel_o       (m_sel_o),
    .m_dat_i       (m_dat_i),
    .m_ack_i       (m_ack_i),
    .m_err_i       (m_err_i),
    .cnt_clear_o   (cnt_clear),
    .cnt_step_o    (cnt_step),
    .cnt_mode_o    (cnt_mode),
    .count_i       (count),
    .last_i        (cnt_last),
    .rd_index_o    (rd_index),
    .wr_en_o       (wr_en),
    .wr_index_o    (wr_index),
    .tag_wr_o      (tag_wr),
    .line_wr_o     (line_wr),
    .tag_rd_i      (tag_rd),
    .line_rd_i     (line_rd)
  );

endmodule

/* design/wb_pkg.sv */
// Wishbone classic bus types for a 32-bit byte-addressed bus with byte selects
package wb_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // ----------------------------------------------------------------------
  // Bus types
  // ----------------------------------------------------------------------
  // Byte address, the low two bits select a byte inside a word
  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [DATA_W-1:0] data_t;

  // One select bit per data byte
  typedef logic [DATA_W/8-1:0] sel_t;

endpackage

/* tb.f */
design/wb_pkg.sv
design/rocache_pkg.sv
design/rocache_region_decode.sv
design/rocache_line_store.sv
design/rocache_beat_counter.sv
design/rocache_ctrl.sv
design/rocache_top.sv
test/tb_rocache.sv

/* test/rocache_testdata.txt */
# Columns: op address write_data expected_data expected_master_cycles (all hex)
# op: n enable (address bit 0), r read, w write, e read that ends in err_o, f flush
n 00000001 00000000 00000000 0
r 10000014 00000000 4a5a0014 4
r 1000001c 00000000 4a5a001c 0
r 10000010 00000000 4a5a0010 0
r 10000240 00000000 4a5a0240 4
r 10000244 00000000 4a5a0244 0
r 10000014 00000000 4a5a0014 0
r 20000000 00000000 7a5a0000 1
r 20000000 00000000 7a5a0000 1
w 20000008 cafe0123 00000000 1
r 20000008 00000000 cafe0123 1
f 00000000 00000000 00000000 0
r 10000014 00000000 4a5a0014 4
r 10000018 00000000 4a5a0018 0
r 10000248 00000000 4a5a0248 4
n 00000000 00000000 00000000 0
r 10000014 00000000 4a5a0014 1
r 1000001c 00000000 4a5a001c 1
n 00000001 00000000 00000000 0
r 1000001c 00000000 4a5a001c 0
e f0000000 00000000 00000000 1
e e0000020 00000000 00000000 4
e e0000024 00000000 00000000 4

/* test/tb_rocache.sv */
// Runs from the project root; fixed windows below, memory model errors at 0xE000_0000 and up
`timescale 1ns/1ps

module tb_rocache;

  localparam wb_pkg::addr_t ERR_BASE = 32'he000_0000;

  logic                clk_i;
  logic                rst_ni;
  logic                enable_i;
  wb_pkg::addr_t       start_addr [rocache_pkg::NR_WINDOWS];
  wb_pkg::addr_t       end_addr   [rocache_pkg::NR_WINDOWS];
  logic                flush_valid_i;
  logic                flush_ready_o;
  logic                cyc_i;
  logic                stb_i;
  logic                we_i;
  wb_pkg::addr_t       adr_i;
  wb_pkg::data_t       dat_i;
  wb_pkg::sel_t        sel_i;
  wb_pkg::data_t       dat_o;
  logic                ack_o;
  logic                err_o;
  logic                m_cyc_o;
  logic                m_stb_o;
  logic                m_we_o;
  wb_pkg::addr_t       m_adr_o;
  wb_pkg::data_t       m_dat_o;
  wb_pkg::sel_t        m_sel_o;
  wb_pkg::data_t       m_dat_i;
  logic                m_ack_i;
  logic                m_err_i;

  // Completed master beats in the current operation
  rocache_pkg::index_t beats;
  wb_pkg::data_t       mem [wb_pkg::addr_t];
  int unsigned         cycle_count;
  int unsigned         cycle_limit = 64;

  // Operations read from the data file
  byte                 op_q [$];
  wb_pkg::addr_t       adr_q [$];
  wb_pkg::data_t       wdat_q [$];
  wb_pkg::data_t       exp_q [$];
  rocache_pkg::index_t cnt_q [$];

  rocache_top dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (enable_i),
    .start_addr_i  (start_addr),
    .end_addr_i    (end_addr),
    .flush_valid_i (flush_valid_i),
    .flush_ready_o (flush_ready_o),
    .cyc_i         (cyc_i),
    .stb_i         (stb_i),
    .we_i          (we_i),
    .adr_i         (adr_i),
    .dat_i         (dat_i),
    .sel_i         (sel_i),
    .dat_o         (dat_o),
    .ack_o         (ack_o),
    .err_o         (err_o),
    .m_cyc_o       (m_cyc_o),
    .m_stb_o       (m_stb_o),
    .m_we_o        (m_we_o),
    .m_adr_o       (m_adr_o),
    .m_dat_o       (m_dat_o),
    .m_sel_o       (m_sel_o),
    .m_dat_i       (m_dat_i),
    .m_ack_i       (m_ack_i),
    .m_err_i       (m_err_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic compare_data(input string name, input wb_pkg::data_t got,
                              input wb_pkg::data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic compare_count(input string name, input rocache_pkg::index_t got,
                               input rocache_pkg::index_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  // Unwritten words read back as their address with a fixed pattern mixed in
  function automatic wb_pkg::data_t memory_word(input wb_pkg::addr_t a);
    return mem.exists(a) ? mem[a] : (a ^ 32'h5a5a_0000);
  endfunction

  // ----------------------------------------------------------------------
  // Memory model on the master port
  // ----------------------------------------------------------------------
  initial begin : memory_model
    int unsigned   waits;
    wb_pkg::addr_t a;
    wb_pkg::data_t word;
    // Wait states are drawn in this process, so its generator takes the seed
    void'($urandom(32'heb1b_87f4));
    m_dat_i = '0;
    m_ack_i = 1'b0;
    m_err_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (m_cyc_o && m_stb_o) begin
        waits = $urandom % 4;
        repeat (waits) begin
          @(posedge clk_i);
          #1;
        end
        a     = {m_adr_o[wb_pkg::ADDR_W-1:2], 2'b00};
        beats = beats + rocache_pkg::index_t'(1);
        if (a >= ERR_BASE) begin
          m_err_i = 1'b1;
        end else if (m_we_o) begin
          word = memory_word(a);
          for (int b = 0; b < wb_pkg::DATA_W / 8; b++) begin
            if (m_sel_o[b]) begin
              word[8*b +: 8] = m_dat_o[8*b +: 8];
            end
          end
          mem[a]  = word;
          m_dat_i = '0;
          m_ack_i = 1'b1;
        end else begin
          m_dat_i = memory_word(a);
          m_ack_i = 1'b1;
        end
        @(posedge clk_i);
        #1;
        m_ack_i = 1'b0;
        m_err_i = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      abort_run("Timeout: the run exceeded its cycle limit");
    end
  end

  // ----------------------------------------------------------------------
  // Slave-side operations
  // ----------------------------------------------------------------------
  // Latency counts falling edges from the request up to the response
  task automatic run_request(input logic we, input wb_pkg::addr_t adr,
                             input wb_pkg::data_t wdat, output logic got_err,
                             output wb_pkg::data_t got_data, output int lat);
    lat = 0;
    @(posedge clk_i);
    #1;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = adr;
    dat_i = wdat;
    sel_i = '1;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!(ack_o || err_o));
    got_err  = err_o;
    got_data = dat_o;
    @(posedge clk_i);
    #1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic run_flush();
    @(posedge clk_i);
    #1;
    flush_valid_i = 1'b1;
    do begin
      @(negedge clk_i);
    end while (!flush_ready_o);
    @(posedge clk_i);
    #1;
    flush_valid_i = 1'b0;
  endtask

  task automatic load_testdata();
    int            fd;
    int            n;
    string         line;
    byte           op;
    wb_pkg::addr_t a;
    wb_pkg::data_t w;
    wb_pkg::data_t e;
    int unsigned   c;
    fd = $fopen("test/rocache_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open test/rocache_testdata.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%c %h %h %h %h", op, a, w, e, c);
        if (n == 5) begin
          op_q.push_back(op);
          adr_q.push_back(a);
          wdat_q.push_back(w);
          exp_q.push_back(e);
          cnt_q.push_back(rocache_pkg::index_t'(c));
        end
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin : main
    logic          got_err;
    wb_pkg::data_t got_data;
    int            lat;
    rst_ni        = 1'b0;
    enable_i      = 1'b0;
    flush_valid_i = 1'b0;
    cyc_i         = 1'b0;
    stb_i         = 1'b0;
    we_i          = 1'b0;
    adr_i         = '0;
    dat_i         = '0;
    sel_i         = '0;
    beats         = '0;
    cycle_count   = 0;
    // Window 1 lies in the error range of the memory model
    start_addr[0] = 32'h1000_0000;
    end_addr[0]   = 32'h1000_1000;
    start_addr[1] = 32'he000_0000;
    end_addr[1]   = 32'he000_1000;
    load_testdata();
    cycle_limit = 200 * op_q.size() + 64;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int i = 0; i < op_q.size(); i++) begin
      beats = '0;
      case (op_q[i])
        "n": begin
          @(posedge clk_i);
          #1;
          enable_i = adr_q[i][0];
        end
        "f": begin
          run_flush();
          compare_count("master cycles", beats, cnt_q[i]);
        end
        "r", "w", "e": begin
          run_request(op_q[i] == "w", adr_q[i], wdat_q[i], got_err, got_data, lat);
          if (op_q[i] == "e" && !got_err) begin
            abort_run($sformatf("Read of %h ended without err_o", adr_q[i]));
          end
          if (op_q[i] != "e" && got_err) begin
            abort_run($sformatf("Access to %h ended with an unexpected err_o", adr_q[i]));
          end
          if (op_q[i] == "r") begin
            compare_data("dat_o", got_data, exp_q[i]);
            // A hit answers two cycles after the idle cycle that sees the request
            if (cnt_q[i] == 0 && lat != 3) begin
              abort_run($sformatf("Hit at %h took %0d cycles instead of 3", adr_q[i], lat));
            end
          end
          compare_count("master cycles", beats, cnt_q[i]);
        end
        default: begin
          abort_run($sformatf("Unknown operation %c in the data file", op_q[i]));
        end
      endcase
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule
